/* vlog.f */
fix_pkg.sv
scene_pkg.sv
vec_dot.sv
quadratic.sv
ray_intersect.sv
tb_clk_gen.sv
ray_intersect_chk.sv
tb_ray_intersect.sv

/* tb_ray_intersect.sv */
`timescale 1ns/1ps

module tb_ray_intersect;

  import fix_pkg::*;
  import scene_pkg::*;

  localparam fix_t ONE = fix_t'(1 << FRAC_BITS);
  localparam fix_t SPH_R2 = DEF_SPHERE_RAD_SQ;
  localparam fix_t CYL_R2 = DEF_CYLINDER_RAD_SQ;
  localparam int WAIT_LIMIT = 1000;
  localparam int N_RANDOM = 20;

  typedef struct {
    string name;
    ray_t  ray;
    obj_t  obj;
    hit_t  exp;
  } case_t;

  logic aclk;
  logic rst;
  ray_t ray;
  obj_t obj;
  logic in_valid;
  logic in_ready;
  hit_t hit;
  logic out_valid;
  logic out_ready;

  integer seed = 32'hd4c7c202;
  case_t  table_q[$];
  case_t  burst_q[$];

  tb_clk_gen #(.PERIOD(10)) clk_gen (.clk(aclk));

  ray_intersect #(
    .SPHERE_RAD_SQ(SPH_R2),
    .CYLINDER_RAD_SQ(CYL_R2)
  ) uut (
    .aclk(aclk),
    .rst(rst),
    .ray(ray),
    .obj(obj),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .hit(hit),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  function automatic vec3_t vec(input fix_t x, input fix_t y, input fix_t z);
    vec3_t v;
    v.x = x;
    v.y = y;
    v.z = z;
    return v;
  endfunction

  // Table objects sit at the origin with the axis along y
  function automatic case_t make_case(input string name, input vec3_t org,
                                      input vec3_t dir, input shape_e sh,
                                      input fix_t t, input logic undef);
    case_t c;
    c.name = name;
    c.ray.origin = org;
    c.ray.dir = dir;
    c.obj.center = vec(0, 0, 0);
    c.obj.axis = vec(0, ONE, 0);
    c.obj.shape = sh;
    c.exp.t = t;
    c.exp.undef = undef;
    return c;
  endfunction

  function automatic fix_t dot3(input vec3_t a, input vec3_t b);
    return fix_mul(a.x, b.x) + fix_mul(a.y, b.y) + fix_mul(a.z, b.z);
  endfunction

  function automatic longint floor_sqrt(input longint v);
    longint lo;
    longint hi;
    longint mid;
    lo = 0;
    hi = longint'(1) << 25;
    while (lo < hi) begin
      mid = (lo + hi + 1) / 2;
      if (mid * mid <= v) lo = mid;
      else hi = mid - 1;
    end
    return lo;
  endfunction

  function automatic hit_t model_hit(input ray_t r, input obj_t o);
    vec3_t  oc;
    fix_t   dca;
    fix_t   occa;
    fix_t   a;
    fix_t   bh;
    fix_t   c;
    fix_t   disc;
    fix_t   t;
    longint s;
    longint num;
    hit_t   h;
    oc.x = r.origin.x - o.center.x;
    oc.y = r.origin.y - o.center.y;
    oc.z = r.origin.z - o.center.z;
    dca = dot3(r.dir, o.axis);
    occa = dot3(oc, o.axis);
    a = dot3(r.dir, r.dir);
    bh = dot3(oc, r.dir);
    c = dot3(oc, oc);
    if (o.shape == shape_cylinder) begin
      a = a - fix_mul(dca, dca);
      bh = bh - fix_mul(dca, occa);
      c = c - fix_mul(occa, occa) - CYL_R2;
    end else begin
      c = c - SPH_R2;
    end
    h.t = '0;
    h.undef = 1'b1;
    disc = fix_mul(bh, bh) - fix_mul(a, c);
    if ((a <= 0) || (disc < 0)) return h;
    s = floor_sqrt(longint'(disc) <<< FRAC_BITS);
    num = -longint'(bh) - s; // Near root first
    t = fix_t'((num <<< FRAC_BITS) / longint'(a));
    if (t >= 0) begin
      h.t = t;
      h.undef = 1'b0;
      return h;
    end
    num = -longint'(bh) + s;
    t = fix_t'((num <<< FRAC_BITS) / longint'(a));
    if (t >= 0) begin
      h.t = t;
      h.undef = 1'b0;
    end
    return h;
  endfunction

  function automatic fix_t rand_fix(input int span);
    return fix_t'(($random(seed) % (span + 1)) * ONE);
  endfunction

  // Small integer grid keeps every intermediate inside Q16.16 range
  function automatic case_t random_case(input int idx);
    case_t c;
    c.name = $sformatf("random_%0d", idx);
    c.ray.origin = vec(rand_fix(4), rand_fix(4), rand_fix(4));
    c.ray.dir = vec(rand_fix(2), rand_fix(2), rand_fix(2));
    c.obj.center = vec(rand_fix(4), rand_fix(4), rand_fix(4));
    c.obj.axis = vec(0, ONE, 0);
    c.obj.shape = shape_e'($random(seed) & 1);
    c.exp = model_hit(c.ray, c.obj);
    return c;
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on a failure");
  endtask

  task automatic check_val(input string name, input logic [63:0] exp,
                           input logic [63:0] act);
    if (exp !== act) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      stop_run("The returned hit does not match the expected value.");
    end
  endtask

  // Entered at a falling edge and left at the falling edge after the transfer
  task automatic send_query(input case_t c);
    int cnt;
    cnt = 0;
    ray = c.ray;
    obj = c.obj;
    in_valid = 1'b1;
    while (!in_ready) begin
      @(negedge aclk);
      cnt++;
      if (cnt > WAIT_LIMIT) stop_run($sformatf("The input was never accepted for %s.", c.name));
    end
    @(negedge aclk);
  endtask

  task automatic collect_result(input case_t c, input logic stall);
    int   cnt;
    logic done;
    cnt = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge aclk);
      if (stall) out_ready = (($random(seed) & 3) != 0);
      else out_ready = 1'b1;
      if (out_valid && out_ready) begin
        check_val(c.name, 64'(c.exp), 64'(hit));
        done = 1'b1;
      end else begin
        cnt++;
        if (cnt > WAIT_LIMIT) stop_run($sformatf("No result came out for %s.", c.name));
      end
    end
  endtask

  always @(negedge aclk) begin
    if (uut.chk.err_cnt != 0) begin
      stop_run("A protocol assertion on ray_intersect failed.");
    end
  end

  initial begin
    rst = 1'b1;
    ray = '0;
    obj = '0;
    in_valid = 1'b0;
    out_ready = 1'b0;

    table_q.push_back(make_case("sphere_front", vec(0, 0, -5 * ONE), vec(0, 0, ONE),
                                shape_sphere, fix_t'(32'h0004_0000), 1'b0));
    table_q.push_back(make_case("sphere_glance", vec(ONE / 2, 0, -5 * ONE), vec(0, 0, ONE),
                                shape_sphere, fix_t'(32'h0004_224d), 1'b0));
    table_q.push_back(make_case("sphere_miss", vec(3 * ONE, 0, -5 * ONE), vec(0, 0, ONE),
                                shape_sphere, fix_t'(0), 1'b1));
    table_q.push_back(make_case("sphere_away", vec(0, 0, -5 * ONE), vec(0, 0, -ONE),
                                shape_sphere, fix_t'(0), 1'b1));
    table_q.push_back(make_case("sphere_inside", vec(0, 0, 0), vec(0, 0, ONE),
                                shape_sphere, fix_t'(32'h0001_0000), 1'b0)); // Far root
    table_q.push_back(make_case("cyl_front", vec(0, 0, -5 * ONE), vec(0, 0, ONE),
                                shape_cylinder, fix_t'(32'h0004_8000), 1'b0));
    table_q.push_back(make_case("cyl_along_axis", vec(0, 0, -5 * ONE), vec(0, ONE, 0),
                                shape_cylinder, fix_t'(0), 1'b1));

    repeat (8) @(negedge aclk);
    rst = 1'b0;
    @(negedge aclk);

    // One query at a time with the output always ready
    foreach (table_q[i]) begin
      send_query(table_q[i]);
      in_valid = 1'b0;
      collect_result(table_q[i], 1'b0);
    end

    foreach (table_q[i]) burst_q.push_back(table_q[i]);
    for (int i = 0; i < N_RANDOM; i++) burst_q.push_back(random_case(i));

    // Back to back queries while the output stalls at random
    @(negedge aclk);
    fork
      begin
        foreach (burst_q[i]) send_query(burst_q[i]);
        in_valid = 1'b0;
      end
      begin
        foreach (burst_q[i]) collect_result(burst_q[i], 1'b1);
      end
    join

    if (uut.chk.err_cnt != 0) begin
      stop_run("A protocol assertion on ray_intersect failed.");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

/* ray_intersect_chk.sv */
`timescale 1ns/1ps

module ray_intersect_chk (
  input logic                  aclk,
  input logic                  rst,
  input logic                  in_ready,
  input logic                  out_valid,
  input logic                  out_ready,
  input scene_pkg::hit_t       hit,
  input logic                  pipe_full,
  input logic                  coef_ready,
  input scene_pkg::quad_coef_t coef
);

  int err_cnt = 0;

  property p_out_hold;
    @(posedge aclk) disable iff (rst)
      (out_valid && !out_ready) |=> (out_valid && $stable(hit));
  endproperty

  property p_reset_quiet;
    @(posedge aclk) rst |=> !out_valid;
  endproperty

  // A full last stage that the solver cannot take must stall the input and keep its coefficients
  property p_front_stall;
    @(posedge aclk) disable iff (rst)
      (pipe_full && !coef_ready) |-> !in_ready ##1 (pipe_full && $stable(coef));
  endproperty

  out_hold_check: assert property (p_out_hold)
    else begin
      err_cnt++;
      $error("Result changed while out_ready was low");
    end

  reset_quiet_check: assert property (p_reset_quiet)
    else begin
      err_cnt++;
      $error("out_valid was high after a reset cycle");
    end

  front_stall_check: assert property (p_front_stall)
    else begin
      err_cnt++;
      $error("The front pipeline did not hold while the solver was busy");
    end

endmodule

bind ray_intersect ray_intersect_chk chk (
  .aclk(aclk),
  .rst(rst),
  .in_ready(in_ready),
  .out_valid(out_valid),
  .out_ready(out_ready),
  .hit(hit),
  .pipe_full(stage_vld[3]),
  .coef_ready(coef_ready),
  .coef(coef_q)
);

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk; // Rising edge first at half a period
  end

endmodule

/* ray_intersect.sv */
`timescale 1ns/1ps

module ray_intersect #(
  parameter fix_pkg::fix_t SPHERE_RAD_SQ = scene_pkg::DEF_SPHERE_RAD_SQ,
  parameter fix_pkg::fix_t CYLINDER_RAD_SQ = scene_pkg::DEF_CYLINDER_RAD_SQ
) (
  input  logic              aclk,
  input  logic              rst,
  input  scene_pkg::ray_t   ray,
  input  scene_pkg::obj_t   obj,
  input  logic              in_valid,
  output logic              in_ready,
  output scene_pkg::hit_t   hit,
  output logic              out_valid,
  input  logic              out_ready
);

  import fix_pkg::*;
  import scene_pkg::*;

  logic       en;
  logic [3:0] stage_vld;

  vec3_t  oc_q;
  vec3_t  dir_q;
  vec3_t  axis_q;
  shape_e shape_s1;
  shape_e shape_s2;
  shape_e shape_s3;

  fix_t dd_dot;
  fix_t ocd_dot;
  fix_t ococ_dot;
  fix_t dca_dot;
  fix_t occa_dot;

  fix_t dca_sq;
  fix_t dca_occa;
  fix_t occa_sq;

  quad_coef_t coef_d;
  quad_coef_t coef_q;
  logic       coef_valid;
  logic       coef_ready;

  // Whole pipeline advances together, bubbles are not squeezed out
  assign en = !stage_vld[3] || coef_ready;
  assign in_ready = en;
  assign coef_valid = stage_vld[3];

  always_ff @(posedge aclk) begin
    if (rst) begin
      stage_vld <= '0;
    end else if (en) begin
      stage_vld <= {stage_vld[2:0], in_valid};
    end
  end

  always_ff @(posedge aclk) begin
    if (en) begin
      oc_q.x <= ray.origin.x - obj.center.x;
      oc_q.y <= ray.origin.y - obj.center.y;
      oc_q.z <= ray.origin.z - obj.center.z;
      dir_q <= ray.dir;
      axis_q <= obj.axis;
      shape_s1 <= obj.shape;
      shape_s2 <= shape_s1; // Follows the two vec_dot stages
      shape_s3 <= shape_s2;
      coef_q <= coef_d;
    end
  end

  vec_dot dd (
    .aclk(aclk), .rst(rst), .en(en),
    .a(dir_q), .b(dir_q), .dot(dd_dot)
  );

  vec_dot ocd (
    .aclk(aclk), .rst(rst), .en(en),
    .a(oc_q), .b(dir_q), .dot(ocd_dot)
  );

  vec_dot ococ (
    .aclk(aclk), .rst(rst), .en(en),
    .a(oc_q), .b(oc_q), .dot(ococ_dot)
  );

  vec_dot dca (
    .aclk(aclk), .rst(rst), .en(en),
    .a(dir_q), .b(axis_q), .dot(dca_dot)
  );

  vec_dot occa (
    .aclk(aclk), .rst(rst), .en(en),
    .a(oc_q), .b(axis_q), .dot(occa_dot)
  );

  always_comb begin
    dca_sq = fix_mul(dca_dot, dca_dot);
    dca_occa = fix_mul(dca_dot, occa_dot);
    occa_sq = fix_mul(occa_dot, occa_dot);
    if (shape_s3 == shape_cylinder) begin
      // Components along the axis drop out of the cylinder equation
      coef_d.a = dd_dot - dca_sq;
      coef_d.bh = ocd_dot - dca_occa;
      coef_d.c = ococ_dot - occa_sq - CYLINDER_RAD_SQ;
    end else begin
      coef_d.a = dd_dot;
      coef_d.bh = ocd_dot;
      coef_d.c = ococ_dot - SPHERE_RAD_SQ;
    end
  end

  quadratic quad (
    .aclk(aclk),
    .rst(rst),
    .coef(coef_q),
    .coef_valid(coef_valid),
    .coef_ready(coef_ready),
    .hit(hit),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

endmodule

/* quadratic.sv */
`timescale 1ns/1ps

module quadratic (
  input  logic                   aclk,
  input  logic                   rst,
  input  scene_pkg::quad_coef_t  coef,
  input  logic                   coef_valid,
  output logic                   coef_ready,
  output scene_pkg::hit_t        hit,
  output logic                   out_valid,
  input  logic                   out_ready
);

  import fix_pkg::*;

  typedef enum logic [2:0] {
    q_idle,
    q_disc,
    q_sqrt,
    q_div_near,
    q_div_far,
    q_done
  } q_state_e;

  localparam int SQRT_STEPS = 24;
  localparam int DIV_STEPS = 48;

  q_state_e state;
  logic [5:0] cnt;

  fix_t a_q;
  fix_t bh_q;
  fix_t c_q;
  fix_t disc;

  logic [47:0] sq_rad;
  logic [24:0] sq_rem;
  logic [23:0] root;
  logic [26:0] sq_try;
  logic [26:0] sq_trial;
  logic [26:0] sq_diff;
  logic [24:0] sq_rem_nx;
  logic [23:0] root_nx;

  logic [47:0] dq;
  logic [31:0] dv_rem;
  logic        neg_q;
  logic [32:0] dv_try;
  logic [32:0] dv_diff;
  logic [31:0] dv_rem_nx;
  logic [47:0] dq_nx;
  fix_t        q_mag;
  fix_t        t_res;

  logic signed [33:0] bh_ext;
  logic signed [33:0] num_near;
  logic signed [33:0] num_far;

  // Dividend magnitude in Q16.16 scaling, the sign is kept aside
  function automatic logic [47:0] num_mag(input logic signed [33:0] num);
    logic [33:0] mag;
    mag = num[33] ? -num : num;
    return {mag[31:0], {FRAC_BITS{1'b0}}};
  endfunction

  assign coef_ready = (state == q_idle);
  assign out_valid = (state == q_done);

  always_comb begin
    disc = fix_mul(bh_q, bh_q) - fix_mul(a_q, c_q);

    // One root bit per cycle, two radicand bits consumed
    sq_try = {sq_rem, sq_rad[47:46]};
    sq_trial = {1'b0, root, 2'b01};
    sq_diff = sq_try - sq_trial;
    if (sq_try >= sq_trial) begin
      sq_rem_nx = sq_diff[24:0];
      root_nx = {root[22:0], 1'b1};
    end else begin
      sq_rem_nx = sq_try[24:0];
      root_nx = {root[22:0], 1'b0};
    end

    // Quotient bits shift in where dividend bits shift out
    dv_try = {dv_rem, dq[47]};
    dv_diff = dv_try - {1'b0, a_q};
    if (dv_try >= {1'b0, a_q}) begin
      dv_rem_nx = dv_diff[31:0];
      dq_nx = {dq[46:0], 1'b1};
    end else begin
      dv_rem_nx = dv_try[31:0];
      dq_nx = {dq[46:0], 1'b0};
    end
    q_mag = dq_nx[31:0];
    t_res = neg_q ? -q_mag : q_mag;

    bh_ext = 34'(bh_q);
    num_near = -bh_ext - $signed({10'b0, root_nx}); // Only read on the last sqrt step
    num_far = -bh_ext + $signed({10'b0, root});
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      state <= q_idle;
      cnt <= '0;
      hit <= '0;
    end else begin
      case (state)
        q_idle: begin
          if (coef_valid) begin
            a_q <= coef.a;
            bh_q <= coef.bh;
            c_q <= coef.c;
            state <= q_disc;
          end
        end
        q_disc: begin
          if ((a_q <= 0) || (disc < 0)) begin
            hit.t <= '0;
            hit.undef <= 1'b1;
            state <= q_done;
          end else begin
            sq_rad <= {disc, {FRAC_BITS{1'b0}}};
            sq_rem <= '0;
            root <= '0;
            cnt <= 6'(SQRT_STEPS - 1);
            state <= q_sqrt;
          end
        end
        q_sqrt: begin
          sq_rad <= {sq_rad[45:0], 2'b00};
          sq_rem <= sq_rem_nx;
          root <= root_nx;
          cnt <= cnt - 1'b1;
          if (cnt == 0) begin
            dq <= num_mag(num_near);
            dv_rem <= '0;
            neg_q <= num_near[33];
            cnt <= 6'(DIV_STEPS - 1);
            state <= q_div_near;
          end
        end
        q_div_near, q_div_far: begin
          dq <= dq_nx;
          dv_rem <= dv_rem_nx;
          cnt <= cnt - 1'b1;
          if (cnt == 0) begin
            if (!t_res[31]) begin
              hit.t <= t_res;
              hit.undef <= 1'b0;
              state <= q_done;
            end else if (state == q_div_near) begin
              dq <= num_mag(num_far); // Near root is behind the origin
              dv_rem <= '0;
              neg_q <= num_far[33];
              cnt <= 6'(DIV_STEPS - 1);
              state <= q_div_far;
            end else begin
              hit.t <= '0;
              hit.undef <= 1'b1;
              state <= q_done;
            end
          end
        end
        q_done: begin
          if (out_ready) begin
            state <= q_idle;
          end
        end
        default: state <= q_idle;
      endcase
    end
  end

endmodule

/* vec_dot.sv */
`timescale 1ns/1ps

module vec_dot (
  input  logic            aclk,
  input  logic            rst,
  input  logic            en,
  input  fix_pkg::vec3_t  a,
  input  fix_pkg::vec3_t  b,
  output fix_pkg::fix_t   dot
);

  import fix_pkg::*;

  fix_t [2:0] prod;

  always_ff @(posedge aclk) begin
    if (rst) begin
      prod <= '0;
    end else if (en) begin
      prod[0] <= fix_mul(a.x, b.x);
      prod[1] <= fix_mul(a.y, b.y);
      prod[2] <= fix_mul(a.z, b.z);
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      dot <= '0;
    end else if (en) begin
      dot <= prod[0] + prod[1] + prod[2]; // Sum wraps like the products
    end
  end

endmodule

/* scene_pkg.sv */
package scene_pkg;

  import fix_pkg::*;

  typedef enum logic {
    shape_sphere   = 1'b0,
    shape_cylinder = 1'b1
  } shape_e;

  typedef struct packed {
    vec3_t origin;
    vec3_t dir;
  } ray_t;

  // The axis is expected to be of unit length
  typedef struct packed {
    vec3_t  center;
    vec3_t  axis;
    shape_e shape;
  } obj_t;

  // Half-b form: a*t^2 + 2*bh*t + c = 0
  typedef struct packed {
    fix_t a;
    fix_t bh;
    fix_t c;
  } quad_coef_t;

  typedef struct packed {
    fix_t t;
    logic undef; // No non-negative root exists
  } hit_t;

  localparam fix_t DEF_SPHERE_RAD_SQ = fix_t'(1 << FRAC_BITS);
  localparam fix_t DEF_CYLINDER_RAD_SQ = fix_t'(1 << (FRAC_BITS - 2));

endpackage

/* fix_pkg.sv */
package fix_pkg;

  localparam int FIX_W = 32;
  localparam int FRAC_BITS = 16;

  // Signed Q16.16 word
  typedef logic signed [FIX_W-1:0] fix_t;

  typedef struct packed {
    fix_t x;
    fix_t y;
    fix_t z;
  } vec3_t;

  // Full product is taken first so no integer bits are lost before the shift
  function automatic fix_t fix_mul(
    input fix_t a,
    input fix_t b
  );
    logic signed [2*FIX_W-1:0] prod;
    prod = (2*FIX_W)'(a) * (2*FIX_W)'(b);
    prod = prod >>> FRAC_BITS; // Arithmetic shift rounds toward minus infinity
    return prod[FIX_W-1:0];
  endfunction

endpackage
